//--- flist.f
hdl/msx_host_pkg.sv
hdl/pipe_slice.sv
hdl/ram_req_arbiter.sv
hdl/ram_resp_router.sv
hdl/sd_activity.sv
hdl/core_control.sv
hdl/msx_host_top.sv
dv/tb_msx_host.sv

//--- Makefile
# Verilator build and run for the MSX host glue

VERILATOR ?= verilator
TOP ?= tb_msx_host
BUILD_DIR ?= obj_dir
FLIST ?= flist.f
VFLAGS ?= --binary --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_msx_host.sv
// MSX host glue directed testbench
`timescale 1ns/1ps

module tb_msx_host;

   localparam int IDLE = 64;
   // Cycle budgets per test, used by the watchdog
   localparam int T_UPLOAD = 3000;
   localparam int T_OPEN = 1000;
   localparam int T_BP = 1500;
   localparam int T_SD = 600;
   localparam int T_CTRL = 400;
   localparam int T_MARGIN = 1000;
   localparam int CLK_NS = 8;

   logic clock_bus;
   logic rst_n;
   logic upload_active;
   msx_host_pkg::upload_req_t upload_req;
   logic upload_valid;
   logic upload_ready;
   msx_host_pkg::cpu_req_t cpu_req;
   logic cpu_valid;
   logic cpu_ready;
   msx_host_pkg::mem_rsp_t cpu_rsp;
   logic cpu_rsp_valid;
   logic cpu_rsp_ready;
   msx_host_pkg::mem_req_t mem_req;
   logic mem_req_valid;
   logic mem_req_ready;
   msx_host_pkg::mem_rsp_t mem_rsp;
   logic mem_rsp_valid;
   logic mem_rsp_ready;
   logic img_mounted;
   logic img_size_nz;
   logic sd_mosi;
   logic sd_miso_int;
   logic sd_miso_ext;
   logic sd_cs;
   logic sd_sck_en;
   logic led_user;
   logic led_disk;
   msx_host_pkg::status_t status;
   logic host_reset;
   logic hard_reset;
   logic core_reset;
   msx_host_pkg::video_cfg_t video;

   integer seed = 32'h4c7c_19b6;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int mem_fires = 0;
   int rsp_delay = 1;
   bit rsp_next_valid = 1'b0;
   logic [7:0] rsp_next_data = 8'h00;
   logic [7:0] sdram [logic [26:0]];
   logic [7:0] shadow [logic [26:0]];
   logic [7:0] pend_q [$];
   msx_host_pkg::mem_rsp_t got_q [$];
   msx_host_pkg::mem_rsp_t exp_q [$];
   logic [26:0] up_addr [32];

   msx_host_top #(.SD_IDLE_CYCLES(IDLE)) uut (.*);

   initial begin
      clock_bus = 1'b0;
      forever #(CLK_NS / 2) clock_bus = ~clock_bus;
   end

   initial begin
      #((T_UPLOAD + T_OPEN + T_BP + T_SD + T_CTRL + T_MARGIN) * CLK_NS);
      $display("Watchdog expired, the run did not finish in time");
      $display("*** FAILED ***");
      $finish;
   end

   // Unwritten SDRAM reads back a pattern of the whole address
   function automatic logic [7:0] fill_byte(input logic [26:0] a);
      return 8'(a ^ (a >> 8) ^ (a >> 16) ^ (a >> 24));
   endfunction

   // ==================================================
   // SDRAM model, in order, 1 to 4 cycles per reply
   // ==================================================
   always @(posedge clock_bus) begin
      if (rst_n && mem_req_valid && mem_req_ready) begin
         mem_fires++;
         if (mem_req.rnw) begin
            pend_q.push_back(sdram.exists(mem_req.addr) ? sdram[mem_req.addr]
                             : fill_byte(mem_req.addr));
         end else begin
            sdram[mem_req.addr] = mem_req.data;
            pend_q.push_back(8'h00);
         end
      end
      if (mem_rsp_valid && mem_rsp_ready) begin
         rsp_next_valid = 1'b0;
      end
      if (!rsp_next_valid && pend_q.size() > 0) begin
         if (rsp_delay <= 1) begin
            rsp_next_data = pend_q.pop_front();
            rsp_next_valid = 1'b1;
            rsp_delay = 1 + ($random(seed) & 3);
         end else begin
            rsp_delay--;
         end
      end
      if (rst_n && cpu_rsp_valid && cpu_rsp_ready) begin
         got_q.push_back(cpu_rsp);
      end
   end

   // Reply lines change on the falling edge only
   always @(negedge clock_bus) begin
      mem_rsp.data = rsp_next_data;
      mem_rsp_valid = rsp_next_valid;
   end

   // ==================================================
   // Compare tasks
   // ==================================================
   task automatic check_rsp(input string name, input msx_host_pkg::mem_rsp_t got,
                            input msx_host_pkg::mem_rsp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_video(input string name, input msx_host_pkg::video_cfg_t got,
                              input msx_host_pkg::video_cfg_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic fail(input string what);
      errors++;
      $display("%s", what);
   endtask

   task automatic end_test(input string name, input int err_before);
      tests++;
      $display("Test %s finished with %0d errors", name, errors - err_before);
   endtask

   // ==================================================
   // Channel drivers, called just after a falling edge
   // ==================================================
   task automatic cpu_wait(input int limit, output bit ok);
      int n;
      n = 0;
      ok = 1'b0;
      while (!ok && n < limit) begin
         @(negedge clock_bus);
         ok = cpu_ready;
         n++;
      end
      if (ok) begin
         @(negedge clock_bus);
         cpu_valid = 1'b0;
      end
   endtask

   // Expected reply follows the decode rules: open bus, read data, or zero
   task automatic push_expected(input msx_host_pkg::cpu_req_t r);
      msx_host_pkg::mem_rsp_t e;
      if (!r.ram_cs) begin
         e.data = 8'hFF;
      end else if (r.rnw) begin
         e.data = shadow.exists(r.addr) ? shadow[r.addr] : fill_byte(r.addr);
      end else begin
         e.data = 8'h00;
         shadow[r.addr] = r.data;
      end
      exp_q.push_back(e);
   endtask

   task automatic cpu_send(input logic [26:0] addr, input logic [7:0] data, input logic rnw,
                           input logic cs, input int limit, output bit ok);
      msx_host_pkg::cpu_req_t r;
      r.addr = addr;
      r.data = data;
      r.rnw = rnw;
      r.ram_cs = cs;
      cpu_req = r;
      cpu_valid = 1'b1;
      cpu_wait(limit, ok);
      if (ok) begin
         push_expected(r);
      end
   endtask

   task automatic cpu_do(input logic [26:0] addr, input logic [7:0] data, input logic rnw,
                         input logic cs);
      bit ok;
      cpu_send(addr, data, rnw, cs, 200, ok);
      if (!ok) begin
         fail("CPU request was not accepted in time");
         cpu_valid = 1'b0;
      end
   endtask

   task automatic upload_write(input logic [26:0] addr, input logic [7:0] data);
      int n;
      bit ok;
      n = 0;
      ok = 1'b0;
      upload_req.addr = addr;
      upload_req.data = data;
      upload_valid = 1'b1;
      while (!ok && n < 200) begin
         @(negedge clock_bus);
         ok = upload_ready;
         n++;
      end
      if (ok) begin
         @(negedge clock_bus);
         shadow[addr] = data;
      end else begin
         fail("Upload write was not accepted in time");
      end
      upload_valid = 1'b0;
   endtask

   // Waits for all expected CPU replies, then compares them in order
   task automatic check_replies(input string name);
      int n;
      n = 0;
      while (got_q.size() < exp_q.size() && n < 600) begin
         @(negedge clock_bus);
         n++;
      end
      if (got_q.size() < exp_q.size()) begin
         fail($sformatf("%s: only %0d of %0d CPU replies arrived", name, got_q.size(),
                        exp_q.size()));
      end else if (got_q.size() > exp_q.size()) begin
         fail($sformatf("%s: %0d CPU replies arrived for %0d requests", name,
                        got_q.size(), exp_q.size()));
      end
      while (got_q.size() > 0 && exp_q.size() > 0) begin
         check_rsp(name, got_q.pop_front(), exp_q.pop_front());
      end
      got_q.delete();
      exp_q.delete();
   endtask

   // ==================================================
   // Tests
   // ==================================================
   task automatic test_upload_readback();
      int e0;
      e0 = errors;
      upload_active = 1'b1;
      @(negedge clock_bus);
      for (int i = 0; i < 32; i++) begin
         up_addr[i] = 27'h10_0000 + 27'(i * 37) + 27'($random(seed) & 7) * 27'h1000;
         upload_write(up_addr[i], 8'($random(seed)));
      end
      upload_active = 1'b0;
      @(negedge clock_bus);
      for (int i = 0; i < 32; i++) begin
         cpu_do(up_addr[i], 8'h00, 1'b1, 1'b1);
      end
      cpu_do(27'h20_0001, 8'h5A, 1'b0, 1'b1);
      cpu_do(27'h20_0001, 8'h00, 1'b1, 1'b1);
      check_replies("upload_readback cpu_rsp");
      end_test("upload_readback", e0);
   endtask

   task automatic test_open_bus();
      int e0;
      int fires;
      e0 = errors;
      fires = mem_fires;
      for (int i = 0; i < 6; i++) begin
         cpu_do(27'h00_0100 + 27'(i), 8'h00, 1'b1, 1'b0);
      end
      check_replies("open_bus cpu_rsp");
      if (mem_fires != fires) begin
         fail("Open-bus reads reached the SDRAM request channel");
      end
      fires = mem_fires;
      for (int i = 0; i < 4; i++) begin
         cpu_do(up_addr[i], 8'h00, 1'b1, 1'b1);
         cpu_do(27'h00_0200 + 27'(i), 8'h00, 1'b1, 1'b0);
      end
      check_replies("open_bus mixed cpu_rsp");
      if (mem_fires != fires + 4) begin
         fail("Mixed open-bus run issued the wrong number of SDRAM requests");
      end
      end_test("open_bus", e0);
   endtask

   task automatic test_back_pressure();
      int e0;
      int accepted;
      bit ok;
      e0 = errors;
      accepted = 0;
      ok = 1'b1;
      cpu_rsp_ready = 1'b0;
      for (int i = 0; i < 12 && ok; i++) begin
         cpu_send(up_addr[8 + i], 8'h00, 1'b1, 1'b1, 40, ok);
         if (ok) begin
            accepted++;
         end
      end
      if (ok) begin
         fail("cpu_ready never dropped while replies were held back");
      end
      if (accepted < msx_host_pkg::TAG_DEPTH) begin
         fail("cpu_ready dropped before the tag FIFO could be full");
      end
      cpu_rsp_ready = 1'b1;
      cpu_wait(200, ok);
      if (ok) begin
         push_expected(cpu_req);
      end else begin
         fail("Stalled CPU read was not accepted after release");
         cpu_valid = 1'b0;
      end
      check_replies("back_pressure cpu_rsp");
      end_test("back_pressure", e0);
   endtask

   task automatic test_sd_activity();
      int e0;
      e0 = errors;
      img_size_nz = 1'b1;
      img_mounted = 1'b1;
      @(negedge clock_bus);
      img_mounted = 1'b0;
      repeat (2) @(negedge clock_bus);
      check_bit("sd_cs", sd_cs, 1'b1);
      check_bit("sd_sck_en", sd_sck_en, 1'b0);
      sd_mosi = ~sd_mosi;
      repeat (3) @(negedge clock_bus);
      check_bit("led_user", led_user, 1'b1);
      check_bit("led_disk", led_disk, 1'b0);
      repeat (IDLE + 10) @(negedge clock_bus);
      check_bit("led_user", led_user, 1'b0);
      check_bit("led_disk", led_disk, 1'b0);
      img_size_nz = 1'b0;
      img_mounted = 1'b1;
      @(negedge clock_bus);
      img_mounted = 1'b0;
      repeat (2) @(negedge clock_bus);
      check_bit("sd_cs", sd_cs, 1'b0);
      check_bit("sd_sck_en", sd_sck_en, 1'b1);
      sd_miso_ext = ~sd_miso_ext;
      repeat (3) @(negedge clock_bus);
      check_bit("led_user", led_user, 1'b0);
      check_bit("led_disk", led_disk, 1'b1);
      end_test("sd_activity", e0);
   endtask

   function automatic msx_host_pkg::video_cfg_t video_rule(input logic [1:0] aspect,
                                                           input logic [2:0] scale);
      msx_host_pkg::video_cfg_t v;
      v.vga_sl = (scale == 3'd0) ? 2'd0 : 2'(scale - 3'd1);
      v.scandoubler = (scale != 3'd0);
      v.hq2x = (scale == 3'd1);
      v.arx = (aspect == 2'd0) ? 12'd4 : 12'(aspect) - 12'd1;
      v.ary = (aspect == 2'd0) ? 12'd3 : 12'd0;
      return v;
   endfunction

   task automatic apply_reset_case(input int bit_sel, input logic mount, input logic hard_exp,
                                   input logic core_exp);
      status = '0;
      case (bit_sel)
         1: status.reset = 1'b1;
         2: status.reset_detach = 1'b1;
         3: status.reset_close = 1'b1;
         4: status.reset_after_mount = 1'b1;
         5: host_reset = 1'b1;
         default: ;
      endcase
      img_mounted = mount;
      repeat (2) @(negedge clock_bus);
      check_bit($sformatf("hard_reset case %0d", bit_sel), hard_reset, hard_exp);
      check_bit($sformatf("core_reset case %0d", bit_sel), core_reset, core_exp);
      host_reset = 1'b0;
      img_mounted = 1'b0;
   endtask

   task automatic test_core_control();
      int e0;
      e0 = errors;
      for (int a = 0; a < 4; a++) begin
         for (int s = 0; s < 8; s++) begin
            status = '0;
            status.aspect = 2'(a);
            status.scale = 3'(s);
            repeat (2) @(negedge clock_bus);
            check_video($sformatf("video a%0d s%0d", a, s), video, video_rule(2'(a), 3'(s)));
         end
      end
      apply_reset_case(0, 1'b0, 1'b0, 1'b0);
      apply_reset_case(1, 1'b0, 1'b1, 1'b1);
      apply_reset_case(2, 1'b0, 1'b0, 1'b1);
      apply_reset_case(3, 1'b0, 1'b0, 1'b1);
      apply_reset_case(4, 1'b0, 1'b0, 1'b0);
      apply_reset_case(4, 1'b1, 1'b0, 1'b1);
      apply_reset_case(0, 1'b1, 1'b0, 1'b0);
      apply_reset_case(5, 1'b0, 1'b1, 1'b1);
      status = '0;
      end_test("core_control", e0);
   endtask

   initial begin
      rst_n = 1'b0;
      upload_active = 1'b0;
      upload_req = '0;
      upload_valid = 1'b0;
      cpu_req = '0;
      cpu_valid = 1'b0;
      cpu_rsp_ready = 1'b1;
      mem_req_ready = 1'b1;
      mem_rsp = '0;
      mem_rsp_valid = 1'b0;
      img_mounted = 1'b0;
      img_size_nz = 1'b0;
      sd_mosi = 1'b0;
      sd_miso_int = 1'b0;
      sd_miso_ext = 1'b0;
      status = '0;
      host_reset = 1'b0;
      repeat (2) @(negedge clock_bus);
      rst_n = 1'b1;
      check_bit("hard_reset", hard_reset, 1'b1);
      check_bit("core_reset", core_reset, 1'b1);
      check_bit("cpu_rsp_valid", cpu_rsp_valid, 1'b0);
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
      check_bit("led_user", led_user, 1'b0);
      check_bit("led_disk", led_disk, 1'b0);
      check_bit("sd_cs", sd_cs, 1'b0);
      @(negedge clock_bus);
      check_bit("hard_reset", hard_reset, 1'b0);
      check_bit("core_reset", core_reset, 1'b0);
      test_upload_readback();
      test_open_bus();
      test_back_pressure();
      test_sd_activity();
      test_core_control();
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- hdl/msx_host_top.sv
// MSX host glue top level
`timescale 1ns/1ps

module msx_host_top #(
   parameter int SD_IDLE_CYCLES = msx_host_pkg::SD_IDLE_CYCLES
) (
   input  logic                      clock_bus,
   input  logic                      rst_n,
   // Loader
   input  logic                      upload_active,
   input  msx_host_pkg::upload_req_t upload_req,
   input  logic                      upload_valid,
   output logic                      upload_ready,
   // CPU bus
   input  msx_host_pkg::cpu_req_t    cpu_req,
   input  logic                      cpu_valid,
   output logic                      cpu_ready,
   output msx_host_pkg::mem_rsp_t    cpu_rsp,
   output logic                      cpu_rsp_valid,
   input  logic                      cpu_rsp_ready,
   // SDRAM channel
   output msx_host_pkg::mem_req_t    mem_req,
   output logic                      mem_req_valid,
   input  logic                      mem_req_ready,
   input  msx_host_pkg::mem_rsp_t    mem_rsp,
   input  logic                      mem_rsp_valid,
   output logic                      mem_rsp_ready,
   // SD card
   input  logic                      img_mounted,
   input  logic                      img_size_nz,
   input  logic                      sd_mosi,
   input  logic                      sd_miso_int,
   input  logic                      sd_miso_ext,
   output logic                      sd_cs,
   output logic                      sd_sck_en,
   output logic                      led_user,
   output logic                      led_disk,
   // OSD control
   input  msx_host_pkg::status_t     status,
   input  logic                      host_reset,
   output logic                      hard_reset,
   output logic                      core_reset,
   output msx_host_pkg::video_cfg_t  video
);

   msx_host_pkg::tagged_req_t arb_req;
   msx_host_pkg::tagged_req_t slice_req;
   msx_host_pkg::tag_kind_t   arb_tag_kind;
   msx_host_pkg::tag_kind_t   push_kind;
   msx_host_pkg::mem_rsp_t    rt_rsp;
   logic arb_req_valid;
   logic arb_req_ready;
   logic arb_tag_push;
   logic arb_hold;
   logic tag_full;
   logic tag_push;
   logic rt_rsp_valid;
   logic rt_rsp_ready;

   // ==================================================
   // RAM request path
   // ==================================================
   assign mem_req = slice_req.req;
   // Tag enters the FIFO on the SDRAM transfer or as an open-bus push
   assign tag_push = (mem_req_valid && mem_req_ready) || arb_tag_push;
   assign push_kind = arb_tag_push ? arb_tag_kind : slice_req.kind;
   // Hold the arbiter while a RAM request is still ahead of SDRAM, keeping tag order
   assign arb_hold = tag_full || arb_req_valid || mem_req_valid;

   ram_req_arbiter u_arbiter (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .upload_active (upload_active),
      .upload_req    (upload_req),
      .upload_valid  (upload_valid),
      .upload_ready  (upload_ready),
      .cpu_req       (cpu_req),
      .cpu_valid     (cpu_valid),
      .cpu_ready     (cpu_ready),
      .req           (arb_req),
      .req_valid     (arb_req_valid),
      .req_ready     (arb_req_ready),
      .tag_push      (arb_tag_push),
      .tag_kind      (arb_tag_kind),
      .tag_full      (arb_hold)
   );

   pipe_slice #(.payload_t(msx_host_pkg::tagged_req_t)) u_req_slice (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .in_data   (arb_req),
      .in_valid  (arb_req_valid),
      .in_ready  (arb_req_ready),
      .out_data  (slice_req),
      .out_valid (mem_req_valid),
      .out_ready (mem_req_ready)
   );

   ram_resp_router u_router (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .tag_push      (tag_push),
      .tag_kind      (push_kind),
      .tag_full      (tag_full),
      .mem_rsp       (mem_rsp),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_ready (mem_rsp_ready),
      .rsp           (rt_rsp),
      .rsp_valid     (rt_rsp_valid),
      .rsp_ready     (rt_rsp_ready)
   );

   pipe_slice #(.payload_t(msx_host_pkg::mem_rsp_t)) u_rsp_slice (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .in_data   (rt_rsp),
      .in_valid  (rt_rsp_valid),
      .in_ready  (rt_rsp_ready),
      .out_data  (cpu_rsp),
      .out_valid (cpu_rsp_valid),
      .out_ready (cpu_rsp_ready)
   );

   // ==================================================
   // Side blocks
   // ==================================================
   sd_activity #(.IDLE_CYCLES(SD_IDLE_CYCLES)) u_sd_activity (
      .clock_bus   (clock_bus),
      .rst_n       (rst_n),
      .img_mounted (img_mounted),
      .img_size_nz (img_size_nz),
      .sd_mosi     (sd_mosi),
      .sd_miso_int (sd_miso_int),
      .sd_miso_ext (sd_miso_ext),
      .sd_cs       (sd_cs),
      .sd_sck_en   (sd_sck_en),
      .led_user    (led_user),
      .led_disk    (led_disk)
   );

   core_control u_core_control (
      .clock_bus      (clock_bus),
      .rst_n          (rst_n),
      .status         (status),
      .host_reset     (host_reset),
      .img_mounted_sd (img_mounted),
      .hard_reset     (hard_reset),
      .core_reset     (core_reset),
      .video          (video)
   );

endmodule

//--- hdl/core_control.sv
// Core reset and video settings decode
`timescale 1ns/1ps

module core_control (
   input  logic                     clock_bus,
   input  logic                     rst_n,
   input  msx_host_pkg::status_t    status,
   input  logic                     host_reset,
   input  logic                     img_mounted_sd,
   output logic                     hard_reset,
   output logic                     core_reset,
   output msx_host_pkg::video_cfg_t video
);

   msx_host_pkg::video_cfg_t video_next;
   logic [2:0] sl;
   logic       hard_next;

   assign hard_next = host_reset || status.reset;

   // ==================================================
   // Video decode
   // ==================================================
   always_comb begin
      sl = (status.scale != 3'd0) ? status.scale - 3'd1 : 3'd0;
      video_next.vga_sl = sl[1:0];
      video_next.scandoubler = (status.scale != 3'd0);
      video_next.hq2x = (status.scale == 3'd1);
      // Aspect 0 keeps the original 4:3 shape
      if (status.aspect == 2'd0) begin
         video_next.arx = 12'd4;
         video_next.ary = 12'd3;
      end else begin
         video_next.arx = {10'd0, status.aspect - 2'd1};
         video_next.ary = 12'd0;
      end
   end

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         hard_reset <= 1'b1;
         core_reset <= 1'b1;
         video <= '0;
      end else begin
         hard_reset <= hard_next;
         core_reset <= hard_next || status.reset_detach || status.reset_close
            || (status.reset_after_mount && img_mounted_sd);
         video <= video_next;
      end
   end

endmodule

//--- hdl/sd_activity.sv
// SD card select and activity LEDs
`timescale 1ns/1ps

module sd_activity #(
   parameter int IDLE_CYCLES = msx_host_pkg::SD_IDLE_CYCLES
) (
   input  logic clock_bus,
   input  logic rst_n,
   input  logic img_mounted,
   input  logic img_size_nz,
   input  logic sd_mosi,
   input  logic sd_miso_int,
   input  logic sd_miso_ext,
   output logic sd_cs,
   output logic sd_sck_en,
   output logic led_user,
   output logic led_disk
);

   localparam int CNT_W = $clog2(IDLE_CYCLES + 1);
   localparam logic [CNT_W-1:0] IDLE_MAX = CNT_W'(IDLE_CYCLES);

   logic             vsd_sel;
   logic             miso;
   logic             old_mosi;
   logic             old_miso;
   logic [CNT_W-1:0] timeout;
   logic             active;

   // Virtual card answers on its own MISO
   assign miso = vsd_sel ? sd_miso_int : sd_miso_ext;
   assign active = (timeout < IDLE_MAX);

   // Physical card is deselected while the virtual one is in use
   assign sd_cs = vsd_sel;
   assign sd_sck_en = !vsd_sel;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         vsd_sel <= 1'b0;
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         timeout <= IDLE_MAX;
         led_user <= 1'b0;
         led_disk <= 1'b0;
      end else begin
         if (img_mounted) begin
            vsd_sel <= img_size_nz;
         end
         old_mosi <= sd_mosi;
         old_miso <= miso;
         // Any line toggle restarts the hold window
         if ((old_mosi ^ sd_mosi) || (old_miso ^ miso)) begin
            timeout <= '0;
         end else if (active) begin
            timeout <= timeout + 1'b1;
         end
         led_user <= vsd_sel && active;
         led_disk <= !vsd_sel && active;
      end
   end

endmodule

//--- hdl/ram_resp_router.sv
// In-order response router with tag FIFO
`timescale 1ns/1ps

module ram_resp_router (
   input  logic                    clock_bus,
   input  logic                    rst_n,
   input  logic                    tag_push,
   input  msx_host_pkg::tag_kind_t tag_kind,
   output logic                    tag_full,
   input  msx_host_pkg::mem_rsp_t  mem_rsp,
   input  logic                    mem_rsp_valid,
   output logic                    mem_rsp_ready,
   output msx_host_pkg::mem_rsp_t  rsp,
   output logic                    rsp_valid,
   input  logic                    rsp_ready
);

   localparam int PTR_W = $clog2(msx_host_pkg::TAG_DEPTH);

   msx_host_pkg::tag_kind_t tag_mem [msx_host_pkg::TAG_DEPTH];
   msx_host_pkg::tag_kind_t head;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   // Tags still waiting for an SDRAM reply
   logic [PTR_W:0]   sdram_cnt;
   logic             empty;
   logic             pop;

   assign empty = (count == '0);
   assign tag_full = (count == (PTR_W + 1)'(msx_host_pkg::TAG_DEPTH));
   assign head = tag_mem[rd_ptr];

   // ==================================================
   // Reply steering by head tag
   // ==================================================
   always_comb begin
      rsp.data = '0;
      rsp_valid = 1'b0;
      mem_rsp_ready = 1'b0;
      pop = 1'b0;
      if (!empty) begin
         case (head)
            msx_host_pkg::TAG_CPU_RD, msx_host_pkg::TAG_CPU_WR: begin
               if (head == msx_host_pkg::TAG_CPU_RD) begin
                  rsp.data = mem_rsp.data;
               end
               rsp_valid = mem_rsp_valid;
               mem_rsp_ready = rsp_ready;
               pop = mem_rsp_valid && rsp_ready;
            end
            // Loader writes are drained without a reply
            msx_host_pkg::TAG_UPLOAD: begin
               mem_rsp_ready = 1'b1;
               pop = mem_rsp_valid;
            end
            default: begin
               rsp.data = msx_host_pkg::OPEN_BUS;
               rsp_valid = 1'b1;
               pop = rsp_ready;
            end
         endcase
      end
   end

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         sdram_cnt <= '0;
      end else begin
         if (tag_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (PTR_W + 1)'(tag_push) - (PTR_W + 1)'(pop);
         sdram_cnt <= sdram_cnt
            + (PTR_W + 1)'(tag_push && tag_kind != msx_host_pkg::TAG_OPEN_BUS)
            - (PTR_W + 1)'(pop && head != msx_host_pkg::TAG_OPEN_BUS);
      end
   end

   always_ff @(posedge clock_bus) begin
      if (tag_push) begin
         tag_mem[wr_ptr] <= tag_kind;
      end
   end

   a_no_orphan_rsp: assert property (@(posedge clock_bus) disable iff (!rst_n)
      mem_rsp_valid |-> sdram_cnt != '0);

endmodule

//--- hdl/ram_req_arbiter.sv
// RAM request arbiter, upload versus CPU
`timescale 1ns/1ps

module ram_req_arbiter (
   input  logic                      clock_bus,
   input  logic                      rst_n,
   input  logic                      upload_active,
   input  msx_host_pkg::upload_req_t upload_req,
   input  logic                      upload_valid,
   output logic                      upload_ready,
   input  msx_host_pkg::cpu_req_t    cpu_req,
   input  logic                      cpu_valid,
   output logic                      cpu_ready,
   output msx_host_pkg::tagged_req_t req,
   output logic                      req_valid,
   input  logic                      req_ready,
   output logic                      tag_push,
   output msx_host_pkg::tag_kind_t   tag_kind,
   input  logic                      tag_full
);

   msx_host_pkg::tag_kind_t next_kind;
   logic can_accept;
   logic up_fire;
   logic cpu_fire;

   // One grant at a time, and never while a previous one is still moving
   assign can_accept = !tag_full && !req_valid && !tag_push && !upload_ready && !cpu_ready;
   assign up_fire = upload_valid && upload_ready;
   assign cpu_fire = cpu_valid && cpu_ready;

   always_comb begin
      if (upload_ready) begin
         next_kind = msx_host_pkg::TAG_UPLOAD;
      end else if (!cpu_req.ram_cs) begin
         next_kind = msx_host_pkg::TAG_OPEN_BUS;
      end else if (cpu_req.rnw) begin
         next_kind = msx_host_pkg::TAG_CPU_RD;
      end else begin
         next_kind = msx_host_pkg::TAG_CPU_WR;
      end
   end

   // ==================================================
   // Grant and issue control
   // ==================================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         upload_ready <= 1'b0;
         cpu_ready <= 1'b0;
         req_valid <= 1'b0;
         tag_push <= 1'b0;
      end else begin
         // Ready answers one cycle after valid is seen
         upload_ready <= upload_active && upload_valid && can_accept;
         cpu_ready <= !upload_active && cpu_valid && can_accept;
         // Non-RAM reads skip SDRAM and go straight to the tag FIFO
         tag_push <= cpu_fire && !cpu_req.ram_cs;
         if (up_fire || (cpu_fire && cpu_req.ram_cs)) begin
            req_valid <= 1'b1;
         end else if (req_ready) begin
            req_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock_bus) begin
      if (up_fire) begin
         req.req.addr <= upload_req.addr;
         req.req.data <= upload_req.data;
         req.req.rnw <= 1'b0;
      end else if (cpu_fire) begin
         req.req.addr <= cpu_req.addr;
         req.req.data <= cpu_req.data;
         req.req.rnw <= cpu_req.rnw;
      end
      if (up_fire || cpu_fire) begin
         req.kind <= next_kind;
         tag_kind <= next_kind;
      end
   end

   a_one_grant: assert property (@(posedge clock_bus) disable iff (!rst_n)
      !(upload_ready && cpu_ready));

endmodule

//--- hdl/pipe_slice.sv
// Valid/ready register slice with skid entry
`timescale 1ns/1ps

module pipe_slice #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clock_bus,
   input  logic     rst_n,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   payload_t skid_data;
   logic     skid_valid;
   logic     in_fire;

   // Skid entry takes the beat that arrives while the output stalls
   assign in_ready = !skid_valid;
   assign in_fire = in_valid && in_ready;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         if (in_fire && out_valid && !out_ready) begin
            skid_valid <= 1'b1;
         end else if (out_ready) begin
            skid_valid <= 1'b0;
         end
         if (!out_valid || out_ready) begin
            out_valid <= skid_valid || in_fire;
         end
      end
   end

   always_ff @(posedge clock_bus) begin
      if (in_ready) begin
         skid_data <= in_data;
      end
      if (!out_valid || out_ready) begin
         out_data <= skid_valid ? skid_data : in_data;
      end
   end

   a_out_stable: assert property (@(posedge clock_bus) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- hdl/msx_host_pkg.sv
// MSX host glue shared definitions
package msx_host_pkg;

   // ==================================================
   // Sizes and constants
   // ==================================================
   localparam int ADDR_W = 27;
   localparam int DATA_W = 8;
   localparam int TAG_DEPTH = 4;
   localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;
   // Hold time of the SD activity LEDs, in clock cycles
   localparam int SD_IDLE_CYCLES = 1_000_000;

   // ==================================================
   // Request and response channels
   // ==================================================
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic              rnw;
      // Access decodes to RAM
      logic              ram_cs;
   } cpu_req_t;

   // Loader traffic is write only
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } upload_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic              rnw;
   } mem_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
   } mem_rsp_t;

   typedef enum logic [1:0] {
      TAG_CPU_RD   = 2'd0,
      TAG_CPU_WR   = 2'd1,
      TAG_UPLOAD   = 2'd2,
      TAG_OPEN_BUS = 2'd3
   } tag_kind_t;

   typedef struct packed {
      mem_req_t  req;
      tag_kind_t kind;
   } tagged_req_t;

   // ==================================================
   // OSD status word and video settings
   // ==================================================
   // Bit positions follow the OSD menu layout, 42 bits
   typedef struct packed {
      logic        border;
      logic        rsvd_40;
      logic        sram_load;
      logic        sram_save;
      logic [15:0] rsvd_37_22;
      logic        reset_close;
      logic [7:0]  rsvd_20_13;
      logic        reset_after_mount;
      logic        rsvd_11;
      logic        reset_detach;
      logic [3:0]  rsvd_9_6;
      logic [2:0]  scale;
      logic [1:0]  aspect;
      logic        reset;
   } status_t;

   typedef struct packed {
      logic [1:0]  vga_sl;
      logic        scandoubler;
      logic        hq2x;
      logic [11:0] arx;
      logic [11:0] ary;
   } video_cfg_t;

endpackage
